//--- Bender.yml
package:
  name: int_pipe

sources:
  # package first, then blocks, then the top level
  - files:
      - common/int_pipe_pkg.sv
      - decode/instr_decode.sv
      - decode/operand_fetch.sv
      - verilog/alu_execute.sv
      - verilog/int_pipe_top.sv

  # testbench, top module int_pipe_tb
  - target: test
    files:
      - test/int_pipe_checker.sv
      - test/int_pipe_monitor.sv
      - test/int_pipe_tb.sv

//--- common/int_pipe_pkg.sv
package int_pipe_pkg;

    // word and register file geometry
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // instruction field widths
    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int funct7_w = 7;
    localparam int imm_w    = 12;

    // major opcodes handled by the pipe
    localparam logic [opcode_w-1:0] opcode_op     = 7'b0110011;
    localparam logic [opcode_w-1:0] opcode_op_imm = 7'b0010011;

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [funct3_w-1:0] funct3_add  = 3'b000;
    localparam logic [funct3_w-1:0] funct3_sll  = 3'b001;
    localparam logic [funct3_w-1:0] funct3_slt  = 3'b010;
    localparam logic [funct3_w-1:0] funct3_sltu = 3'b011;
    localparam logic [funct3_w-1:0] funct3_xor  = 3'b100;
    localparam logic [funct3_w-1:0] funct3_sr   = 3'b101;
    localparam logic [funct3_w-1:0] funct3_or   = 3'b110;
    localparam logic [funct3_w-1:0] funct3_and  = 3'b111;

    // funct7 that turns add into sub and srl into sra
    localparam logic [funct7_w-1:0] funct7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // r view of the instruction word
    typedef struct packed {
        logic [funct7_w-1:0]   funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [funct3_w-1:0]   funct3;
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } r_type_s;

    // i view, imm overlays funct7 and rs2
    typedef struct packed {
        logic [imm_w-1:0]      imm;
        logic [reg_addr_w-1:0] rs1;
        logic [funct3_w-1:0]   funct3;
        logic [reg_addr_w-1:0] rd;
        logic [opcode_w-1:0]   opcode;
    } i_type_s;

    typedef union packed {
        r_type_s r;
        i_type_s i;
    } rv_instr_u;

    // where an operand comes from
    typedef enum logic [1:0] {
        fwd_regfile,
        fwd_ex,
        fwd_wb
    } fwd_sel_e;

endpackage

//--- decode/instr_decode.sv
module instr_decode (
    input  int_pipe_pkg::rv_instr_u                  instr_i,
    output int_pipe_pkg::alu_op_e                    alu_op_o,
    output logic                                     use_imm_o,
    output logic                                     reg_write_o,
    output logic [int_pipe_pkg::reg_addr_w-1:0]      rd_o,
    output logic [int_pipe_pkg::xlen-1:0]            imm_o
);

    import int_pipe_pkg::*;

    logic is_op;
    logic is_op_imm;
    logic alt;
    alu_op_e op_sel;

    // opcode, funct3 and funct7 come from the r view
    assign is_op     = (instr_i.r.opcode == opcode_op);
    assign is_op_imm = (instr_i.r.opcode == opcode_op_imm);
    assign alt       = (instr_i.r.funct7 == funct7_alt);

    // funct3 to alu op
    always_comb begin
        unique case (instr_i.r.funct3)
            funct3_add: begin
                // sub exists only in the register form
                op_sel = (is_op && alt) ? alu_sub : alu_add;
            end
            funct3_sll:  op_sel = alu_sll;
            funct3_slt:  op_sel = alu_slt;
            funct3_sltu: op_sel = alu_sltu;
            funct3_xor:  op_sel = alu_xor;
            funct3_sr: begin
                // imm[11:5] picks arithmetic shift on srai too
                op_sel = alt ? alu_sra : alu_srl;
            end
            funct3_or:   op_sel = alu_or;
            funct3_and:  op_sel = alu_and;
            default:     op_sel = alu_add;
        endcase
    end

    // unsupported opcodes become an add that writes nothing
    always_comb begin
        alu_op_o    = alu_add;
        use_imm_o   = 1'b0;
        reg_write_o = 1'b0;
        rd_o        = '0;
        if (is_op || is_op_imm) begin
            alu_op_o    = op_sel;
            use_imm_o   = is_op_imm;
            reg_write_o = 1'b1;
            rd_o        = instr_i.r.rd;
        end
    end

    // sign extend the 12 bit immediate
    // shift forms only use the low five bits, so funct7 bits riding along are harmless
    assign imm_o = {{(xlen-imm_w){instr_i.i.imm[imm_w-1]}}, instr_i.i.imm};

endmodule

//--- decode/operand_fetch.sv
module operand_fetch (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  int_pipe_pkg::rv_instr_u              instr_i,
    input  logic                                 ex_valid_i,
    input  logic                                 ex_reg_write_i,
    input  logic [int_pipe_pkg::reg_addr_w-1:0]  ex_rd_i,
    input  logic [int_pipe_pkg::xlen-1:0]        ex_result_i,
    input  logic                                 wb_valid_i,
    input  logic [int_pipe_pkg::reg_addr_w-1:0]  wb_rd_i,
    input  logic [int_pipe_pkg::xlen-1:0]        wb_result_i,
    input  logic                                 wr_en_i,
    output logic [int_pipe_pkg::xlen-1:0]        rs1_data_o,
    output logic [int_pipe_pkg::xlen-1:0]        rs2_data_o
);

    import int_pipe_pkg::*;

    logic [xlen-1:0] regs_q [num_regs];

    // index 0 is rs1, index 1 is rs2
    logic [reg_addr_w-1:0] rs_addr [2];
    fwd_sel_e              fwd_sel [2];
    logic [xlen-1:0]       rs_data [2];

    logic ex_hit_en;
    logic wb_hit_en;

    // architectural state, written when a retire record is taken
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int n = 0; n < num_regs; n++) begin
                regs_q[n] <= '0;
            end
        end else if (wr_en_i && (wb_rd_i != '0)) begin
            // x0 never gets written
            regs_q[wb_rd_i] <= wb_result_i;
        end
    end

    assign rs_addr[0] = instr_i.r.rs1;
    assign rs_addr[1] = instr_i.r.rs2;

    // only live producers that write a register are candidates
    assign ex_hit_en = ex_valid_i && ex_reg_write_i;
    // wb rd is already zero for non-writing ops
    assign wb_hit_en = wb_valid_i;

    // source select per operand
    // ex is younger than wb, so it wins
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            fwd_sel[k] = fwd_regfile;
            if (rs_addr[k] != '0) begin
                if (ex_hit_en && (ex_rd_i == rs_addr[k])) begin
                    fwd_sel[k] = fwd_ex;
                end else if (wb_hit_en && (wb_rd_i == rs_addr[k])) begin
                    fwd_sel[k] = fwd_wb;
                end
            end
        end
    end

    // operand mux
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            unique case (fwd_sel[k])
                fwd_ex:  rs_data[k] = ex_result_i;
                fwd_wb:  rs_data[k] = wb_result_i;
                default: begin
                    // x0 reads zero no matter what sits in the array
                    rs_data[k] = (rs_addr[k] == '0) ? '0 : regs_q[rs_addr[k]];
                end
            endcase
        end
    end

    assign rs1_data_o = rs_data[0];
    assign rs2_data_o = rs_data[1];

endmodule

//--- int_pipe.f
common/int_pipe_pkg.sv
decode/instr_decode.sv
decode/operand_fetch.sv
verilog/alu_execute.sv
verilog/int_pipe_top.sv
test/int_pipe_checker.sv
test/int_pipe_monitor.sv
test/int_pipe_tb.sv

//--- test/int_pipe_checker.sv
module int_pipe_checker (
    input logic                                 clk,
    input logic                                 rst_n_i,
    input logic                                 instr_ready_i,
    input logic                                 ret_valid_i,
    input logic                                 ret_ready_i,
    input logic [int_pipe_pkg::reg_addr_w-1:0]  ret_rd_i,
    input logic [int_pipe_pkg::xlen-1:0]        ret_data_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench at the end of the run
    int fail_count = 0;

    // a cycle spent in reset leaves the retire port empty and input open
    a_reset_idle: assert property (@(posedge clk)
        !rst_n_i |=> (!ret_valid_i && instr_ready_i))
        else begin
            fail_count++;
            $error("retire port not idle after a reset cycle");
        end

    // stalled record must not move
    a_ret_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ret_valid_i && !ret_ready_i) |=>
            (ret_valid_i && $stable(ret_rd_i) && $stable(ret_data_i)))
        else begin
            fail_count++;
            $error("retire record changed while stalled");
        end

    // input side opens exactly when the pipe can advance
    a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_ready_i == !(ret_valid_i && !ret_ready_i))
        else begin
            fail_count++;
            $error("instr_ready_o does not follow the advance rule");
        end

endmodule

//--- test/int_pipe_monitor.sv
module int_pipe_monitor (
    input logic                                 clk,
    input logic                                 rst_n_i,
    input logic                                 instr_ready_i,
    input logic                                 ret_valid_i,
    input logic                                 ret_ready_i,
    input logic [int_pipe_pkg::reg_addr_w-1:0]  ret_rd_i,
    input logic [int_pipe_pkg::xlen-1:0]        ret_data_i
);

    timeunit 1ns;
    timeprecision 1ps;

    import int_pipe_pkg::*;

    // expected records, oldest first
    string                 exp_name [$];
    logic [reg_addr_w-1:0] exp_rd   [$];
    logic [xlen-1:0]       exp_data [$];

    int   error_count  = 0;
    int   retire_count = 0;
    logic rst_n_q      = 1'b0;

    // called by the driver when an instruction is taken
    task automatic expect_retire(input string name, input logic [reg_addr_w-1:0] rd,
                                 input logic [xlen-1:0] data);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    function automatic int pending_count();
        return exp_name.size();
    endfunction

    always @(posedge clk) begin
        string                 name;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        // first edge out of reset
        if (rst_n_i && !rst_n_q) begin
            if (ret_valid_i !== 1'b0 || instr_ready_i !== 1'b1) begin
                $display("pipe not empty and open right after reset");
                error_count++;
            end
        end
        rst_n_q <= rst_n_i;
        // one record per handshake, in order
        if (rst_n_i && ret_valid_i && ret_ready_i) begin
            retire_count++;
            if (exp_name.size() == 0) begin
                $display("unexpected retire of rd %0d with nothing pending", ret_rd_i);
                error_count++;
            end else begin
                name = exp_name.pop_front();
                rd   = exp_rd.pop_front();
                data = exp_data.pop_front();
                if (ret_rd_i !== rd || ret_data_i !== data) begin
                    $display("ERROR %s: expected rd %0d data 0x%08h, actual rd %0d data 0x%08h",
                             name, rd, data, ret_rd_i, ret_data_i);
                    error_count++;
                end
            end
        end
    end

endmodule

//--- test/int_pipe_tb.sv
module int_pipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import int_pipe_pkg::*;

    localparam int clk_period      = 20;  // ns
    localparam int reset_cycles    = 5;
    localparam int cycles_per_test = 20;

    logic                  clk;
    logic                  rst_n_i;
    logic                  instr_valid_i;
    rv_instr_u             instr_i;
    logic                  instr_ready_o;
    logic                  ret_valid_o;
    logic                  ret_ready_i;
    logic [reg_addr_w-1:0] ret_rd_o;
    logic [xlen-1:0]       ret_data_o;

    integer seed = 32'h654;
    bit     table_built = 1'b0;
    int     total_errors;

    // stimulus table
    string                 t_name  [$];
    logic [xlen-1:0]       t_instr [$];
    logic [reg_addr_w-1:0] t_rd    [$];
    logic [xlen-1:0]       t_data  [$];

    int_pipe_top DUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .ret_valid_o   (ret_valid_o),
        .ret_ready_i   (ret_ready_i),
        .ret_rd_o      (ret_rd_o),
        .ret_data_o    (ret_data_o)
    );

    int_pipe_monitor u_monitor (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_ready_i (instr_ready_o),
        .ret_valid_i   (ret_valid_o),
        .ret_ready_i   (ret_ready_i),
        .ret_rd_i      (ret_rd_o),
        .ret_data_i    (ret_data_o)
    );

    bind int_pipe_top int_pipe_checker u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_ready_i (instr_ready_o),
        .ret_valid_i   (ret_valid_o),
        .ret_ready_i   (ret_ready_i),
        .ret_rd_i      (ret_rd_o),
        .ret_data_i    (ret_data_o)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // random retire back-pressure with ready about three cycles in four
    always @(posedge clk) begin
        ret_ready_i <= (($random(seed) & 3) != 0);
    end

    function automatic logic [31:0] encode_op(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_op_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic add_entry(input string name, input logic [31:0] instr,
                             input logic [4:0] rd, input logic [31:0] data);
        t_name.push_back(name);
        t_instr.push_back(instr);
        t_rd.push_back(rd);
        t_data.push_back(data);
    endtask

    // expected values follow rv32i with register state carried from earlier rows
    task automatic build_table();
        add_entry("reset_add_x0", encode_op(7'h00, 0, 0, 3'b000, 0), 0, 32'h00000000);
        // op-imm forms load x1 with -5 and x2 with 100
        add_entry("addi_neg", encode_op_imm(12'hffb, 0, 3'b000, 1), 1, 32'hfffffffb);
        add_entry("addi_pos", encode_op_imm(12'h064, 0, 3'b000, 2), 2, 32'h00000064);
        add_entry("slti", encode_op_imm(12'hffc, 1, 3'b010, 3), 3, 32'h00000001);
        add_entry("sltiu", encode_op_imm(12'hffc, 1, 3'b011, 4), 4, 32'h00000001);
        add_entry("xori", encode_op_imm(12'hfff, 2, 3'b100, 5), 5, 32'hffffff9b);
        add_entry("ori", encode_op_imm(12'hff0, 2, 3'b110, 6), 6, 32'hfffffff4);
        add_entry("andi", encode_op_imm(12'hff0, 1, 3'b111, 7), 7, 32'hfffffff0);
        add_entry("slli", encode_op_imm(12'h004, 2, 3'b001, 8), 8, 32'h00000640);
        add_entry("srli", encode_op_imm(12'h01c, 1, 3'b101, 9), 9, 32'h0000000f);
        add_entry("srai", encode_op_imm(12'h402, 1, 3'b101, 10), 10, 32'hfffffffe);
        // register forms
        add_entry("add", encode_op(7'h00, 2, 1, 3'b000, 11), 11, 32'h0000005f);
        add_entry("sub", encode_op(7'h20, 1, 2, 3'b000, 12), 12, 32'h00000069);
        add_entry("sll", encode_op(7'h00, 3, 2, 3'b001, 13), 13, 32'h000000c8);
        add_entry("slt", encode_op(7'h00, 2, 1, 3'b010, 14), 14, 32'h00000001);
        add_entry("sltu", encode_op(7'h00, 2, 1, 3'b011, 15), 15, 32'h00000000);
        add_entry("xor", encode_op(7'h00, 5, 1, 3'b100, 16), 16, 32'h00000060);
        add_entry("srl", encode_op(7'h00, 3, 1, 3'b101, 17), 17, 32'h7ffffffd);
        add_entry("sra", encode_op(7'h20, 3, 1, 3'b101, 18), 18, 32'hfffffffd);
        add_entry("or", encode_op(7'h00, 8, 2, 3'b110, 19), 19, 32'h00000664);
        add_entry("and", encode_op(7'h00, 7, 6, 3'b111, 20), 20, 32'hfffffff0);
        // dependence chain through ex and wb
        add_entry("chain_addi", encode_op_imm(12'h007, 0, 3'b000, 21), 21, 32'h00000007);
        add_entry("chain_add_ex1", encode_op(7'h00, 21, 21, 3'b000, 21), 21, 32'h0000000e);
        add_entry("chain_add_ex2", encode_op(7'h00, 21, 21, 3'b000, 21), 21, 32'h0000001c);
        add_entry("chain_sub_ex", encode_op(7'h20, 2, 21, 3'b000, 22), 22, 32'hffffffb8);
        add_entry("chain_addi_wb", encode_op_imm(12'h001, 21, 3'b000, 23), 23, 32'h0000001d);
        add_entry("chain_xor_ex_wb", encode_op(7'h00, 23, 22, 3'b100, 24), 24, 32'hffffffa5);
        add_entry("chain_sll_wb", encode_op(7'h00, 21, 24, 3'b001, 25), 25, 32'h50000000);
        // x0 and an unknown opcode
        add_entry("addi_x0", encode_op_imm(12'h07b, 0, 3'b000, 0), 0, 32'h0000007b);
        add_entry("read_x0_ex", encode_op(7'h00, 0, 0, 3'b000, 27), 27, 32'h00000000);
        add_entry("read_x0_wb", encode_op_imm(12'h009, 0, 3'b000, 28), 28, 32'h00000009);
        add_entry("unsupported_lui", 32'h12345eb7, 0, 32'h00000000);
        add_entry("after_unsupported", encode_op_imm(12'h001, 29, 3'b000, 29), 29, 32'h00000001);
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        ret_ready_i   = 1'b1;
        build_table();
        table_built = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int n = 0; n < t_name.size(); n++) begin
            instr_valid_i <= 1'b1;
            instr_i       <= t_instr[n];
            // taken on the edge where ready was high
            do @(posedge clk); while (!instr_ready_o);
            u_monitor.expect_retire(t_name[n], t_rd[n], t_data[n]);
        end
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        while (u_monitor.pending_count() != 0) @(posedge clk);
        // a few idle cycles to catch stray retires
        repeat (4) @(posedge clk);
        total_errors = u_monitor.error_count + DUT.u_checker.fail_count;
        $display("retired %0d of %0d, errors %0d (monitor %0d, assertions %0d)",
                 u_monitor.retire_count, t_name.size(), total_errors,
                 u_monitor.error_count, DUT.u_checker.fail_count);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog scaled by table length
    initial begin
        wait (table_built);
        #(t_name.size() * cycles_per_test * clk_period);
        $display("timeout, %0d retire records never arrived", u_monitor.pending_count());
        $display("retired %0d of %0d, errors %0d", u_monitor.retire_count, t_name.size(),
                 u_monitor.error_count + DUT.u_checker.fail_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verilog/alu_execute.sv
module alu_execute (
    input  int_pipe_pkg::alu_op_e             alu_op_i,
    input  logic                              use_imm_i,
    input  logic [int_pipe_pkg::xlen-1:0]     rs1_data_i,
    input  logic [int_pipe_pkg::xlen-1:0]     rs2_data_i,
    input  logic [int_pipe_pkg::xlen-1:0]     imm_i,
    output logic [int_pipe_pkg::xlen-1:0]     result_o
);

    import int_pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    // decode branch picks the mux, fetch branch supplies the operands
    assign op_a = rs1_data_i;
    assign op_b = use_imm_i ? imm_i : rs2_data_i;

    // rv32i shifts look at five bits only
    assign shamt = op_b[4:0];

    // comparisons
    assign lt_signed   = ($signed(op_a) < $signed(op_b));
    assign lt_unsigned = (op_a < op_b);

    always_comb begin
        unique case (alu_op_i)
            alu_add:  result_o = op_a + op_b;
            alu_sub:  result_o = op_a - op_b;
            alu_sll:  result_o = op_a << shamt;
            alu_slt:  result_o = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result_o = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  result_o = op_a ^ op_b;
            alu_srl:  result_o = op_a >> shamt;
            alu_sra: begin
                // arithmetic shift keeps the sign bit
                result_o = $unsigned($signed(op_a) >>> shamt);
            end
            alu_or:   result_o = op_a | op_b;
            alu_and:  result_o = op_a & op_b;
            default:  result_o = '0;
        endcase
    end

endmodule

//--- verilog/int_pipe_top.sv
module int_pipe_top (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 instr_valid_i,
    input  int_pipe_pkg::rv_instr_u              instr_i,
    output logic                                 instr_ready_o,
    output logic                                 ret_valid_o,
    input  logic                                 ret_ready_i,
    output logic [int_pipe_pkg::reg_addr_w-1:0]  ret_rd_o,
    output logic [int_pipe_pkg::xlen-1:0]        ret_data_o
);

    import int_pipe_pkg::*;

    logic advance;
    logic retire;

    // decode stage register
    logic      id_valid_q;
    rv_instr_u id_instr_q;

    // decode and fetch outputs
    alu_op_e               id_alu_op;
    logic                  id_use_imm;
    logic                  id_reg_write;
    logic [reg_addr_w-1:0] id_rd;
    logic [xlen-1:0]       id_imm;
    logic [xlen-1:0]       id_rs1_data;
    logic [xlen-1:0]       id_rs2_data;

    // execute stage register, control word first
    logic                  ex_valid_q;
    alu_op_e               ex_alu_op_q;
    logic                  ex_use_imm_q;
    logic                  ex_reg_write_q;
    logic [reg_addr_w-1:0] ex_rd_q;
    logic [xlen-1:0]       ex_rs1_data_q;
    logic [xlen-1:0]       ex_rs2_data_q;
    logic [xlen-1:0]       ex_imm_q;
    logic [xlen-1:0]       ex_result;

    // writeback register
    logic                  wb_valid_q;
    logic [reg_addr_w-1:0] wb_rd_q;
    logic [xlen-1:0]       wb_result_q;

    // whole pipe moves unless a retire record is stuck
    assign advance       = !wb_valid_q || ret_ready_i;
    assign instr_ready_o = advance;
    assign retire        = wb_valid_q && ret_ready_i;

    // valid bits and control
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid_q     <= 1'b0;
            ex_valid_q     <= 1'b0;
            ex_reg_write_q <= 1'b0;
            wb_valid_q     <= 1'b0;
        end else if (advance) begin
            id_valid_q     <= instr_valid_i;
            ex_valid_q     <= id_valid_q;
            ex_reg_write_q <= id_reg_write;
            wb_valid_q     <= ex_valid_q;
        end
    end

    // payload, meaningful only under its valid bit
    always_ff @(posedge clk) begin
        if (advance) begin
            id_instr_q    <= instr_i;
            ex_alu_op_q   <= id_alu_op;
            ex_use_imm_q  <= id_use_imm;
            ex_rd_q       <= id_rd;
            ex_rs1_data_q <= id_rs1_data;
            ex_rs2_data_q <= id_rs2_data;
            ex_imm_q      <= id_imm;
            // non-writing ops retire as x0 with zero
            wb_rd_q       <= ex_reg_write_q ? ex_rd_q : '0;
            wb_result_q   <= ex_reg_write_q ? ex_result : '0;
        end
    end

    instr_decode u_instr_decode (
        .instr_i     (id_instr_q),
        .alu_op_o    (id_alu_op),
        .use_imm_o   (id_use_imm),
        .reg_write_o (id_reg_write),
        .rd_o        (id_rd),
        .imm_o       (id_imm)
    );

    // same instruction as decode, in parallel
    operand_fetch u_operand_fetch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_i        (id_instr_q),
        .ex_valid_i     (ex_valid_q),
        .ex_reg_write_i (ex_reg_write_q),
        .ex_rd_i        (ex_rd_q),
        .ex_result_i    (ex_result),
        .wb_valid_i     (wb_valid_q),
        .wb_rd_i        (wb_rd_q),
        .wb_result_i    (wb_result_q),
        .wr_en_i        (retire),
        .rs1_data_o     (id_rs1_data),
        .rs2_data_o     (id_rs2_data)
    );

    alu_execute u_alu_execute (
        .alu_op_i   (ex_alu_op_q),
        .use_imm_i  (ex_use_imm_q),
        .rs1_data_i (ex_rs1_data_q),
        .rs2_data_i (ex_rs2_data_q),
        .imm_i      (ex_imm_q),
        .result_o   (ex_result)
    );

    // retire record straight from the writeback register
    assign ret_valid_o = wb_valid_q;
    assign ret_rd_o    = wb_rd_q;
    assign ret_data_o  = wb_result_q;

endmodule
